// ==== hdl/tsmem_config.svh ====
`ifndef TSMEM_CONFIG_SVH
`define TSMEM_CONFIG_SVH

// word address width of the shared memory
`define DRAM_AW 21

// memory word width
`define DRAM_DW 16

// log2 of words really stored, upper address bits alias
`define MEM_DEPTH_LOG2 12

// words fetched per video line
`define LINE_WORDS 8

// cpu byte address width, the bit above it selects registers
`define CPU_AW 22

`endif

// ==== hdl/dram_pkg.sv ====
`include "tsmem_config.svh"

package dram_pkg;

    // one access to the shared word memory
    typedef struct packed {
        logic [`DRAM_AW-1:0] addr;
        logic                rnw;
        logic [1:0]          bsel;
        logic [`DRAM_DW-1:0] wdata;
    } dram_req_t;

    // who holds the current slot
    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_VIDEO,
        OWN_CPU,
        OWN_DMA
    } dram_owner_e;

endpackage

// ==== hdl/zbus_pkg.sv ====
`include "tsmem_config.svh"

package zbus_pkg;

    // wishbone classic request, top adr bit picks the register space
    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [`CPU_AW:0] adr;
        logic [7:0]       dat;
    } wb_req_t;

    typedef struct packed {
        logic       ack;
        logic [7:0] dat;
    } wb_rsp_t;

    // single register write from the cpu side
    typedef struct packed {
        logic       stb;
        logic [3:0] idx;
        logic [7:0] dat;
    } reg_wr_t;

    typedef enum logic [3:0] {
        DMA_SRC0  = 4'd0,
        DMA_SRC1  = 4'd1,
        DMA_SRC2  = 4'd2,
        DMA_DST0  = 4'd3,
        DMA_DST1  = 4'd4,
        DMA_DST2  = 4'd5,
        DMA_LEN   = 4'd6,
        DMA_START = 4'd7,
        VPAGE     = 4'd8
    } zreg_e;

endpackage

// ==== hdl/dram_arbiter.sv ====
`timescale 1ns/1ps

module dram_arbiter (
    input  logic                  fclk,
    input  logic                  rst,

    input  logic                  video_req,
    input  logic                  cpu_req,
    input  logic                  dma_req,
    input  dram_pkg::dram_req_t   video_rq,
    input  dram_pkg::dram_req_t   cpu_rq,
    input  dram_pkg::dram_req_t   dma_rq,

    output logic                  video_next,
    output logic                  cpu_next,
    output logic                  dma_next,
    output logic                  video_strobe,
    output logic                  cpu_strobe,
    output logic                  dma_strobe,

    output dram_pkg::dram_req_t   mem_req,
    output logic                  mem_valid,
    output dram_pkg::dram_owner_e mem_owner
);
    import dram_pkg::*;

    logic [1:0]  phase;
    logic        c1;
    logic        c2;
    logic        c3;
    dram_owner_e pick;
    dram_owner_e own;
    dram_req_t   slot_rq;

    assign c1 = (phase == 2'd1);
    assign c2 = (phase == 2'd2);
    assign c3 = (phase == 2'd3);

    always_ff @(posedge fclk) begin
        if (rst) begin
            phase <= 2'd0;
        end else begin
            phase <= phase + 2'd1;
        end
    end

    // fixed priority, video first
    always_comb begin
        pick = OWN_NONE;
        if (video_req) begin
            pick = OWN_VIDEO;
        end else if (cpu_req) begin
            pick = OWN_CPU;
        end else if (dma_req) begin
            pick = OWN_DMA;
        end
    end

    always_ff @(posedge fclk) begin
        if (rst) begin
            own <= OWN_NONE;
        end else if (c3) begin
            own <= pick;
        end
    end

    always_ff @(posedge fclk) begin
        if (c3) begin
            case (pick)
                OWN_VIDEO: slot_rq <= video_rq;
                OWN_CPU:   slot_rq <= cpu_rq;
                OWN_DMA:   slot_rq <= dma_rq;
                default:   slot_rq <= slot_rq;
            endcase
        end
    end

    assign video_next = c3 && (pick == OWN_VIDEO);
    assign cpu_next   = c3 && (pick == OWN_CPU);
    assign dma_next   = c3 && (pick == OWN_DMA);

    // array acts at the end of c1, data is out in c2
    assign video_strobe = c2 && (own == OWN_VIDEO);
    assign cpu_strobe   = c2 && (own == OWN_CPU);
    assign dma_strobe   = c2 && (own == OWN_DMA);

    assign mem_req   = slot_rq;
    assign mem_valid = c1 && (own != OWN_NONE);
    assign mem_owner = own;

endmodule

// ==== hdl/dram_array.sv ====
`timescale 1ns/1ps
`include "tsmem_config.svh"

module dram_array (
    input  logic                fclk,
    input  dram_pkg::dram_req_t mem_req,
    input  logic                mem_valid,
    output logic [`DRAM_DW-1:0] rddata
);

    localparam int DEPTH = 1 << `MEM_DEPTH_LOG2;

    logic [`DRAM_DW-1:0]        mem [0:DEPTH-1];
    logic [`MEM_DEPTH_LOG2-1:0] widx;

    // higher word address bits simply alias
    assign widx = mem_req.addr[`MEM_DEPTH_LOG2-1:0];

    always_ff @(posedge fclk) begin
        if (mem_valid) begin
            if (mem_req.rnw) begin
                rddata <= mem[widx];
            end else begin
                if (mem_req.bsel[0]) begin
                    mem[widx][7:0] <= mem_req.wdata[7:0];
                end
                if (mem_req.bsel[1]) begin
                    mem[widx][`DRAM_DW-1:8] <= mem_req.wdata[`DRAM_DW-1:8];
                end
            end
        end
    end

    // read data holds until the next read slot

endmodule

// ==== hdl/zmem_port.sv ====
`timescale 1ns/1ps
`include "tsmem_config.svh"

module zmem_port (
    input  logic                fclk,
    input  logic                rst,
    input  zbus_pkg::wb_req_t   wb_in,
    output zbus_pkg::wb_rsp_t   wb_out,
    output logic                mem_req_flag,
    output dram_pkg::dram_req_t mem_rq,
    input  logic                mem_next,
    input  logic                mem_strobe,
    input  logic [`DRAM_DW-1:0] rddata,
    output zbus_pkg::reg_wr_t   reg_wr,
    input  logic                dma_busy,
    input  logic                video_busy
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_MREQ,
        S_MWAIT,
        S_ACK
    } state_t;

    state_t     state;
    logic [7:0] rdat;
    logic [7:0] status;
    logic       hit_reg;

    assign status  = {6'b0, video_busy, dma_busy};
    assign hit_reg = wb_in.adr[`CPU_AW];

    always_ff @(posedge fclk) begin
        if (rst) begin
            state        <= S_IDLE;
            mem_req_flag <= 1'b0;
            reg_wr.stb   <= 1'b0;
        end else begin
            reg_wr.stb <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (wb_in.cyc && wb_in.stb) begin
                        if (hit_reg) begin
                            // every register reads back as status
                            reg_wr.stb <= wb_in.we;
                            reg_wr.idx <= wb_in.adr[3:0];
                            reg_wr.dat <= wb_in.dat;
                            rdat       <= status;
                            state      <= S_ACK;
                        end else begin
                            mem_rq.addr  <= wb_in.adr[`CPU_AW-1:1];
                            mem_rq.rnw   <= !wb_in.we;
                            mem_rq.bsel  <= wb_in.adr[0] ? 2'b10 : 2'b01;
                            mem_rq.wdata <= {wb_in.dat, wb_in.dat};
                            mem_req_flag <= 1'b1;
                            state        <= S_MREQ;
                        end
                    end
                end
                S_MREQ: begin
                    if (mem_next) begin
                        mem_req_flag <= 1'b0;
                        state        <= S_MWAIT;
                    end
                end
                S_MWAIT: begin
                    // strobe comes for writes as well
                    if (mem_strobe) begin
                        rdat  <= mem_rq.bsel[1] ? rddata[`DRAM_DW-1:8] : rddata[7:0];
                        state <= S_ACK;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    assign wb_out = '{ack: (state == S_ACK), dat: rdat};

endmodule

// ==== hdl/dma_engine.sv ====
`timescale 1ns/1ps
`include "tsmem_config.svh"

module dma_engine (
    input  logic                fclk,
    input  logic                rst,
    input  zbus_pkg::reg_wr_t   reg_wr,
    output logic                busy,
    output logic                mem_req_flag,
    output dram_pkg::dram_req_t mem_rq,
    input  logic                mem_next,
    input  logic                mem_strobe,
    input  logic [`DRAM_DW-1:0] rddata
);
    import zbus_pkg::*;

    typedef enum logic [1:0] {
        D_IDLE,
        D_RD,
        D_WT,
        D_WR
    } dstate_t;

    dstate_t             state;
    logic [`DRAM_AW-1:0] src;
    logic [`DRAM_AW-1:0] dst;
    logic [7:0]          len;
    logic [7:0]          cnt;
    logic [`DRAM_DW-1:0] data;
    logic                start;
    logic                wr_taken;

    assign start    = reg_wr.stb && (reg_wr.idx == DMA_START) && (state == D_IDLE);
    assign wr_taken = (state == D_WR) && mem_next;

    always_ff @(posedge fclk) begin
        if (rst) begin
            state <= D_IDLE;
        end else begin
            case (state)
                D_IDLE: begin
                    if (start) begin
                        state <= D_RD;
                    end
                end
                D_RD: begin
                    if (mem_next) begin
                        state <= D_WT;
                    end
                end
                D_WT: begin
                    if (mem_strobe) begin
                        state <= D_WR;
                    end
                end
                default: begin
                    if (mem_next) begin
                        state <= (cnt == 8'd0) ? D_IDLE : D_RD;
                    end
                end
            endcase
        end
    end

    // registers take writes only while idle
    always_ff @(posedge fclk) begin
        if (state == D_IDLE && reg_wr.stb) begin
            case (reg_wr.idx)
                DMA_SRC0: src[7:0]   <= reg_wr.dat;
                DMA_SRC1: src[15:8]  <= reg_wr.dat;
                DMA_SRC2: src[20:16] <= reg_wr.dat[4:0];
                DMA_DST0: dst[7:0]   <= reg_wr.dat;
                DMA_DST1: dst[15:8]  <= reg_wr.dat;
                DMA_DST2: dst[20:16] <= reg_wr.dat[4:0];
                DMA_LEN:  len        <= reg_wr.dat;
                default:  len        <= len;
            endcase
        end
        if (wr_taken) begin
            src <= src + 1'b1;
            dst <= dst + 1'b1;
            cnt <= cnt - 8'd1;
        end else if (start) begin
            cnt <= len;
        end
        if (state == D_WT && mem_strobe) begin
            data <= rddata;
        end
    end

    assign busy         = (state != D_IDLE);
    assign mem_req_flag = (state == D_RD) || (state == D_WR);
    assign mem_rq = '{
        addr:  (state == D_WR) ? dst : src,
        rnw:   (state != D_WR),
        bsel:  2'b11,
        wdata: data
    };

endmodule

// ==== hdl/video_fetch.sv ====
`timescale 1ns/1ps
`include "tsmem_config.svh"

module video_fetch (
    input  logic                fclk,
    input  logic                rst,
    input  zbus_pkg::reg_wr_t   reg_wr,
    input  logic                line_start,
    output logic                busy,
    output logic                mem_req_flag,
    output dram_pkg::dram_req_t mem_rq,
    input  logic                mem_next,
    input  logic                mem_strobe,
    input  logic [`DRAM_DW-1:0] rddata,
    output logic                pix_valid,
    output logic [`DRAM_DW-1:0] pix_data
);
    import zbus_pkg::*;

    localparam int CW = $clog2(`LINE_WORDS + 1);

    logic [7:0]    vpage;
    logic [CW-1:0] rq_cnt;
    logic [CW-1:0] st_cnt;

    // requests issued so far, stops at a full line
    assign mem_req_flag = busy && (rq_cnt != CW'(`LINE_WORDS));
    assign mem_rq = '{
        addr:  `DRAM_AW'({vpage, 8'h00}) + `DRAM_AW'(rq_cnt),
        rnw:   1'b1,
        bsel:  2'b11,
        wdata: '0
    };

    always_ff @(posedge fclk) begin
        if (rst) begin
            vpage     <= 8'h00;
            busy      <= 1'b0;
            rq_cnt    <= '0;
            st_cnt    <= '0;
            pix_valid <= 1'b0;
        end else begin
            pix_valid <= mem_strobe;
            if (reg_wr.stb && reg_wr.idx == VPAGE) begin
                vpage <= reg_wr.dat;
            end
            if (!busy) begin
                if (line_start) begin
                    busy   <= 1'b1;
                    rq_cnt <= '0;
                    st_cnt <= '0;
                end
            end else begin
                if (mem_next) begin
                    rq_cnt <= rq_cnt + 1'b1;
                end
                if (mem_strobe) begin
                    st_cnt <= st_cnt + 1'b1;
                    // last word back ends the line
                    if (st_cnt == CW'(`LINE_WORDS - 1)) begin
                        busy <= 1'b0;
                    end
                end
            end
        end
    end

    always_ff @(posedge fclk) begin
        if (mem_strobe) begin
            pix_data <= rddata;
        end
    end

endmodule

// ==== hdl/tsmem_top.sv ====
`timescale 1ns/1ps
`include "tsmem_config.svh"

module tsmem_top (
    input  logic                fclk,
    input  logic                rst,
    input  zbus_pkg::wb_req_t   wb_in,
    output zbus_pkg::wb_rsp_t   wb_out,
    input  logic                line_start,
    output logic                dma_busy,
    output logic                pix_valid,
    output logic [`DRAM_DW-1:0] pix_data
);
    import dram_pkg::*;
    import zbus_pkg::*;

    dram_req_t           video_rq;
    dram_req_t           cpu_rq;
    dram_req_t           dma_rq;
    dram_req_t           mem_req;
    logic                video_req;
    logic                cpu_req;
    logic                dma_req;
    logic                video_next;
    logic                cpu_next;
    logic                dma_next;
    logic                video_strobe;
    logic                cpu_strobe;
    logic                dma_strobe;
    logic                mem_valid;
    logic [`DRAM_DW-1:0] rddata;
    reg_wr_t             reg_wr;
    logic                video_busy;

    dram_arbiter arbiter (
        .fclk(fclk),
        .rst(rst),
        .video_req(video_req),
        .cpu_req(cpu_req),
        .dma_req(dma_req),
        .video_rq(video_rq),
        .cpu_rq(cpu_rq),
        .dma_rq(dma_rq),
        .video_next(video_next),
        .cpu_next(cpu_next),
        .dma_next(dma_next),
        .video_strobe(video_strobe),
        .cpu_strobe(cpu_strobe),
        .dma_strobe(dma_strobe),
        .mem_req(mem_req),
        .mem_valid(mem_valid),
        .mem_owner()
    );

    dram_array dram (
        .fclk(fclk),
        .mem_req(mem_req),
        .mem_valid(mem_valid),
        .rddata(rddata)
    );

    zmem_port zmem (
        .fclk(fclk),
        .rst(rst),
        .wb_in(wb_in),
        .wb_out(wb_out),
        .mem_req_flag(cpu_req),
        .mem_rq(cpu_rq),
        .mem_next(cpu_next),
        .mem_strobe(cpu_strobe),
        .rddata(rddata),
        .reg_wr(reg_wr),
        .dma_busy(dma_busy),
        .video_busy(video_busy)
    );

    dma_engine dma (
        .fclk(fclk),
        .rst(rst),
        .reg_wr(reg_wr),
        .busy(dma_busy),
        .mem_req_flag(dma_req),
        .mem_rq(dma_rq),
        .mem_next(dma_next),
        .mem_strobe(dma_strobe),
        .rddata(rddata)
    );

    video_fetch video (
        .fclk(fclk),
        .rst(rst),
        .reg_wr(reg_wr),
        .line_start(line_start),
        .busy(video_busy),
        .mem_req_flag(video_req),
        .mem_rq(video_rq),
        .mem_next(video_next),
        .mem_strobe(video_strobe),
        .rddata(rddata),
        .pix_valid(pix_valid),
        .pix_data(pix_data)
    );

endmodule

// ==== test/tb_tsmem.sv ====
`timescale 1ns/1ps
`include "tsmem_config.svh"

module tb_tsmem;
    import zbus_pkg::*;

    localparam int MODEL_BYTES = 2 << `MEM_DEPTH_LOG2;
    localparam int ACK_LIMIT = 400;

    logic                fclk;
    logic                rst;
    wb_req_t             wb_in;
    wb_rsp_t             wb_out;
    logic                line_start;
    logic                dma_busy;
    logic                pix_valid;
    logic [`DRAM_DW-1:0] pix_data;

    // byte image of the shared memory
    logic [7:0]          ref_mem [0:MODEL_BYTES-1];
    logic [`DRAM_DW-1:0] pix_q [$];
    logic                seen_cyc;
    int                  value_errors;
    int                  proto_errors;
    int                  timeout_errors;

    tsmem_top uut (
        .fclk(fclk),
        .rst(rst),
        .wb_in(wb_in),
        .wb_out(wb_out),
        .line_start(line_start),
        .dma_busy(dma_busy),
        .pix_valid(pix_valid),
        .pix_data(pix_data)
    );

    initial begin
        fclk = 1'b0;
        forever begin
            #2 fclk = ~fclk;
        end
    end

    always @(negedge fclk) begin
        if (!rst && pix_valid) begin
            pix_q.push_back(pix_data);
        end
    end

    quiet_before_first_cycle: assert property (@(posedge fclk) disable iff (rst)
        !seen_cyc |-> (!wb_out.ack && !pix_valid && !dma_busy))
        else begin
            proto_errors = proto_errors + 1;
            $display("ERROR: ack, pix_valid or dma_busy active before the first bus cycle");
        end

    ack_within_cycle: assert property (@(posedge fclk) disable iff (rst)
        wb_out.ack |-> wb_in.cyc)
        else begin
            proto_errors = proto_errors + 1;
            $display("ERROR: ack pulsed while cyc was low");
        end

    ack_one_wide: assert property (@(posedge fclk) disable iff (rst)
        wb_out.ack |=> !wb_out.ack)
        else begin
            proto_errors = proto_errors + 1;
            $display("ERROR: ack stayed high for more than one cycle");
        end

    pix_one_wide: assert property (@(posedge fclk) disable iff (rst)
        pix_valid |=> !pix_valid)
        else begin
            proto_errors = proto_errors + 1;
            $display("ERROR: pix_valid stayed high for more than one cycle");
        end

    // upper byte address bits alias onto the array
    function automatic int model_index(input logic [`CPU_AW-1:0] addr);
        return int'(addr[`MEM_DEPTH_LOG2:0]);
    endfunction

    task automatic check_value(input string test, input string what,
                               input logic [15:0] exp, input logic [15:0] act);
        assert (act === exp)
            else begin
                value_errors = value_errors + 1;
                $display("MISMATCH %s %s expected 0x%h actual 0x%h", test, what, exp, act);
            end
    endtask

    task automatic bus_cycle(input logic we, input logic [`CPU_AW:0] adr,
                             input logic [7:0] wdat, output logic [7:0] rdat);
        int n;
        n = 0;
        @(posedge fclk);
        wb_in <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
        seen_cyc <= 1'b1;
        @(negedge fclk);
        while (!wb_out.ack && n < ACK_LIMIT) begin
            @(negedge fclk);
            n++;
        end
        if (wb_out.ack) begin
            rdat = wb_out.dat;
        end else begin
            timeout_errors = timeout_errors + 1;
            $display("ERROR: no ack for the bus cycle at address 0x%h", adr);
            rdat = 8'hxx;
        end
        @(posedge fclk);
        wb_in <= '{default: '0};
    endtask

    task automatic cpu_write(input logic [`CPU_AW-1:0] addr, input logic [7:0] dat);
        logic [7:0] rd;
        bus_cycle(1'b1, {1'b0, addr}, dat, rd);
        ref_mem[model_index(addr)] = dat;
    endtask

    task automatic cpu_read_check(input string test, input logic [`CPU_AW-1:0] addr);
        logic [7:0] got;
        bus_cycle(1'b0, {1'b0, addr}, 8'h00, got);
        check_value(test, $sformatf("byte 0x%h", addr),
                    {8'h00, ref_mem[model_index(addr)]}, {8'h00, got});
    endtask

    task automatic reg_write(input logic [3:0] idx, input logic [7:0] dat);
        logic [7:0] rd;
        bus_cycle(1'b1, {1'b1, {(`CPU_AW-4){1'b0}}, idx}, dat, rd);
    endtask

    task automatic read_status(output logic [7:0] st);
        bus_cycle(1'b0, {1'b1, {(`CPU_AW){1'b0}}}, 8'h00, st);
    endtask

    task automatic fill_words(input logic [`DRAM_AW-1:0] wa, input int words);
        logic [31:0]        r;
        logic [`CPU_AW-1:0] ba;
        for (int i = 0; i < words; i++) begin
            r = $urandom;
            ba = {wa + `DRAM_AW'(i), 1'b0};
            cpu_write(ba, r[7:0]);
            cpu_write(ba | `CPU_AW'(1), r[15:8]);
        end
    endtask

    // register writes, then the copy applied to the model
    task automatic start_dma(input logic [`DRAM_AW-1:0] src, input logic [`DRAM_AW-1:0] dst,
                             input logic [7:0] len);
        int idx_s;
        int idx_d;
        reg_write(DMA_SRC0, src[7:0]);
        reg_write(DMA_SRC1, src[15:8]);
        reg_write(DMA_SRC2, {3'b000, src[20:16]});
        reg_write(DMA_DST0, dst[7:0]);
        reg_write(DMA_DST1, dst[15:8]);
        reg_write(DMA_DST2, {3'b000, dst[20:16]});
        reg_write(DMA_LEN, len);
        reg_write(DMA_START, 8'h01);
        for (int i = 0; i <= int'(len); i++) begin
            idx_s = model_index({src + `DRAM_AW'(i), 1'b0});
            idx_d = model_index({dst + `DRAM_AW'(i), 1'b0});
            ref_mem[idx_d] = ref_mem[idx_s];
            ref_mem[idx_d + 1] = ref_mem[idx_s + 1];
        end
    endtask

    task automatic check_copy(input string test, input logic [`DRAM_AW-1:0] src,
                              input logic [`DRAM_AW-1:0] dst, input int words);
        logic [`CPU_AW-1:0] sa;
        logic [`CPU_AW-1:0] da;
        for (int i = 0; i < words; i++) begin
            sa = {src + `DRAM_AW'(i), 1'b0};
            da = {dst + `DRAM_AW'(i), 1'b0};
            cpu_read_check(test, da);
            cpu_read_check(test, da | `CPU_AW'(1));
            cpu_read_check(test, sa);
            cpu_read_check(test, sa | `CPU_AW'(1));
        end
    endtask

    task automatic wait_dma(input logic level, input int limit);
        int n;
        n = 0;
        @(negedge fclk);
        while (dma_busy !== level && n < limit) begin
            @(negedge fclk);
            n++;
        end
        if (dma_busy !== level) begin
            timeout_errors = timeout_errors + 1;
            $display("ERROR: dma_busy did not reach %0b within %0d cycles", level, limit);
        end
    endtask

    task automatic wait_pix(input int count, input int limit);
        int n;
        n = 0;
        @(negedge fclk);
        while (pix_q.size() < count && n < limit) begin
            @(negedge fclk);
            n++;
        end
        if (pix_q.size() < count) begin
            timeout_errors = timeout_errors + 1;
            $display("ERROR: only %0d of %0d pixel words arrived", pix_q.size(), count);
        end
    endtask

    task automatic wait_video_idle(input int limit);
        logic [7:0] st;
        int         n;
        n = 0;
        read_status(st);
        while (st[1] && n < limit) begin
            read_status(st);
            n++;
        end
        if (st[1]) begin
            timeout_errors = timeout_errors + 1;
            $display("ERROR: video fetch still running after %0d status reads", limit);
        end
    endtask

    task automatic pulse_line();
        @(posedge fclk);
        line_start <= 1'b1;
        @(posedge fclk);
        line_start <= 1'b0;
    endtask

    task automatic check_line(input string test, input logic [7:0] page);
        logic [`DRAM_AW-1:0] wa;
        int                  idx;
        check_value(test, "pix_valid pulses", 16'(`LINE_WORDS), 16'(pix_q.size()));
        for (int i = 0; i < pix_q.size() && i < `LINE_WORDS; i++) begin
            wa = `DRAM_AW'({page, 8'h00}) + `DRAM_AW'(i);
            idx = model_index({wa, 1'b0});
            check_value(test, $sformatf("pixel word %0d", i),
                        {ref_mem[idx + 1], ref_mem[idx]}, pix_q[i]);
        end
    endtask

    task automatic finish_run();
        $display("errors: value %0d, protocol %0d, timeout %0d",
                 value_errors, proto_errors, timeout_errors);
        if (value_errors + proto_errors + timeout_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    initial begin
        logic [31:0]        r;
        logic [7:0]         st;
        logic [`CPU_AW-1:0] addrs [0:15];
        int                 n;

        void'($urandom(32'h1c60_b630));
        rst = 1'b1;
        wb_in = '0;
        line_start = 1'b0;
        seen_cyc = 1'b0;
        value_errors = 0;
        proto_errors = 0;
        timeout_errors = 0;
        repeat (5) @(posedge fclk);
        rst <= 1'b0;

        // idle outputs after reset
        repeat (12) @(posedge fclk);

        // random bytes, one full word, and an alias above the array
        for (int i = 0; i < 16; i++) begin
            r = $urandom;
            addrs[i] = r[`CPU_AW-1:0];
            r = $urandom;
            cpu_write(addrs[i], r[7:0]);
        end
        cpu_write(22'h00_0100, 8'h5a);
        cpu_write(22'h00_0101, 8'ha5);
        cpu_write(22'h2a_0123, 8'h3c);
        for (int i = 0; i < 16; i++) begin
            cpu_read_check("byte_rw", addrs[i]);
        end
        cpu_read_check("byte_rw", 22'h00_0100);
        cpu_read_check("byte_rw", 22'h00_0101);
        cpu_read_check("byte_rw", 22'h2a_0123);
        cpu_read_check("byte_rw", 22'h00_0123);

        // dma copy of six words
        fill_words(21'h00100, 6);
        start_dma(21'h00100, 21'h00300, 8'd5);
        wait_dma(1'b1, 20);
        n = 0;
        read_status(st);
        @(negedge fclk);
        while (dma_busy && n < 200) begin
            check_value("dma_copy", "status busy bit", 16'd1, {15'd0, st[0]});
            read_status(st);
            @(negedge fclk);
            n++;
        end
        if (dma_busy) begin
            timeout_errors = timeout_errors + 1;
            $display("ERROR: dma copy did not finish during status polling");
        end
        read_status(st);
        check_value("dma_copy", "status busy bit", 16'd0, {15'd0, st[0]});
        check_copy("dma_copy", 21'h00100, 21'h00300, 6);

        // one video line, second line_start lands mid fetch
        reg_write(VPAGE, 8'h0a);
        fill_words(21'h00a00, `LINE_WORDS);
        pix_q.delete();
        pulse_line();
        wait_pix(2, 200);
        pulse_line();
        wait_pix(`LINE_WORDS, 400);
        wait_video_idle(50);
        check_line("video_line", 8'h0a);

        // all three peers at once
        reg_write(VPAGE, 8'h0b);
        fill_words(21'h00b00, `LINE_WORDS);
        fill_words(21'h00180, 4);
        pix_q.delete();
        start_dma(21'h00180, 21'h00380, 8'd3);
        pulse_line();
        for (int i = 0; i < 12; i++) begin
            r = $urandom;
            cpu_write(22'h00_0800 + `CPU_AW'(i), r[7:0]);
            cpu_read_check("contention", 22'h00_0800 + `CPU_AW'(i));
        end
        wait_dma(1'b0, 2000);
        wait_pix(`LINE_WORDS, 400);
        wait_video_idle(50);
        check_line("contention", 8'h0b);
        check_copy("contention", 21'h00180, 21'h00380, 4);

        finish_run();
    end

endmodule

// ==== project.f ====
+incdir+hdl
hdl/dram_pkg.sv
hdl/zbus_pkg.sv
hdl/dram_arbiter.sv
hdl/dram_array.sv
hdl/zmem_port.sv
hdl/dma_engine.sv
hdl/video_fetch.sv
hdl/tsmem_top.sv
test/tb_tsmem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator and run the testbench from the project root
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module tb_tsmem -o tb_tsmem
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_tsmem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
    exit 0
fi
exit 1
